// File: logic/bus_pkg.sv
package bus_pkg;

    // ----------------------------------------------------------
    // Wishbone classic bus of the control block
    // ----------------------------------------------------------

    // Byte address inside the block
    localparam int wb_addr_w = 8;

    // One bus word, whole-word writes only
    localparam int wb_data_w = 32;

    typedef logic [wb_addr_w-1:0] wb_addr_t;
    typedef logic [wb_data_w-1:0] wb_data_t;

endpackage

// File: logic/io_map_pkg.sv
package io_map_pkg;

    import bus_pkg::*;

    // ----------------------------------------------------------
    // Register map
    // ----------------------------------------------------------
    localparam wb_addr_t led_addr      = 8'h00;
    localparam wb_addr_t tmr_addr      = 8'h04;
    localparam wb_addr_t spi_ctrl_addr = 8'h20;
    localparam wb_addr_t spi_data_addr = 8'h24;

    typedef logic [2:0]  led_t;
    typedef logic [7:0]  spi_byte_t;
    typedef logic [31:0] tmr_t;

    // Bit 2 lit out of reset
    localparam led_t led_reset = 3'b100;

    // SPI control fields
    localparam int spi_cs_bit   = 0;
    localparam int spi_busy_bit = 1;

    // 48 MHz clock down to 1 us
    localparam int                   tmr_div      = 48;
    localparam int                   tmr_pre_w    = $clog2(tmr_div);
    localparam logic [tmr_pre_w-1:0] tmr_pre_last = tmr_pre_w'(tmr_div - 1);

endpackage

// File: logic/spi_master.sv
`timescale 1ns/1ps

module spi_master import io_map_pkg::*; (
    input  logic      clk_48,
    input  logic      rst_n,
    input  logic      spi_load,
    input  spi_byte_t spi_load_data,
    input  logic      spi_miso,
    output logic      spi_clk,
    output logic      spi_mosi,
    output spi_byte_t spi_rx_data,
    output logic      spi_busy
);

    typedef enum logic [1:0] {
        idle,
        low,
        high
    } spi_phase_t;

    spi_phase_t phase;
    logic [2:0] bits_left;
    spi_byte_t  shreg;

    // ----------------------------------------------------------
    // Clock phases, mode 3
    // ----------------------------------------------------------
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= idle;
            bits_left <= '0;
            spi_clk   <= 1'b1;
            spi_mosi  <= 1'b1;
        end else if (spi_load) begin
            // New byte always wins, even mid-transfer
            phase     <= low;
            bits_left <= 3'd7;
            spi_clk   <= 1'b0;
            spi_mosi  <= spi_load_data[7];
        end else begin
            case (phase)
                low: begin
                    spi_clk <= 1'b1;
                    phase   <= (bits_left == '0) ? idle : high;
                end
                high: begin
                    spi_clk   <= 1'b0;
                    spi_mosi  <= shreg[7];
                    bits_left <= bits_left - 1'b1;
                    phase     <= low;
                end
                default: begin
                    phase <= idle;
                end
            endcase
        end
    end

    // Out at the top, in at the bottom
    always_ff @(posedge clk_48) begin
        if (spi_load) begin
            shreg <= {spi_load_data[6:0], 1'b0};
        end else if (phase == low) begin
            // Sampled on the rising edge
            shreg[0] <= spi_miso;
        end else if (phase == high) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    assign spi_rx_data = shreg;

    // Drops as the clock returns high after bit 0
    assign spi_busy = (phase != idle);

endmodule

// File: logic/us_timer.sv
`timescale 1ns/1ps

module us_timer import io_map_pkg::*; (
    input  logic clk_48,
    input  logic rst_n,
    output tmr_t tmr_count
);

    logic [tmr_pre_w-1:0] prescale;
    logic                 tick;

    // One pulse per microsecond
    assign tick = (prescale == tmr_pre_last);

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            prescale  <= '0;
            tmr_count <= '0;
        end else begin
            if (tick) begin
                prescale  <= '0;
                // Free running, wraps
                tmr_count <= tmr_count + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

// File: logic/io_regs.sv
`timescale 1ns/1ps

module io_regs import bus_pkg::*, io_map_pkg::*; (
    input  logic      clk_48,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  wb_data_t  wb_dat_w,
    input  spi_byte_t spi_rx_data,
    input  logic      spi_busy,
    input  tmr_t      tmr_count,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack,
    output led_t      led,
    output logic      spi_cs,
    output logic      spi_load,
    output spi_byte_t spi_load_data
);

    wb_addr_t word_adr;
    logic     req;
    logic     wr;

    // Word aligned decode
    assign word_adr = {wb_adr[wb_addr_w-1:2], 2'b00};

    // New request, not yet acked
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign wr  = req && wb_we;

    // ----------------------------------------------------------
    // Handshake and control registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            led    <= led_reset;
            spi_cs <= 1'b1;
        end else begin
            wb_ack <= req;
            if (wr) begin
                case (word_adr)
                    led_addr: begin
                        led <= wb_dat_w[$bits(led_t)-1:0];
                    end
                    spi_ctrl_addr: begin
                        // Busy field is read only
                        spi_cs <= wb_dat_w[spi_cs_bit];
                    end
                    default: begin
                        led <= led;
                    end
                endcase
            end
        end
    end

    // Data register write starts a transfer
    assign spi_load      = wr && (word_adr == spi_data_addr);
    assign spi_load_data = wb_dat_w[$bits(spi_byte_t)-1:0];

    // ----------------------------------------------------------
    // Read data
    // ----------------------------------------------------------
    always_comb begin
        wb_dat_r = '0;
        case (word_adr)
            led_addr: begin
                wb_dat_r[$bits(led_t)-1:0] = led;
            end
            tmr_addr: begin
                wb_dat_r = tmr_count;
            end
            spi_ctrl_addr: begin
                wb_dat_r[spi_cs_bit]   = spi_cs;
                wb_dat_r[spi_busy_bit] = spi_busy;
            end
            spi_data_addr: begin
                wb_dat_r[$bits(spi_byte_t)-1:0] = spi_rx_data;
            end
            default: begin
                // Unmapped reads as zero
                wb_dat_r = '0;
            end
        endcase
    end

endmodule

// File: logic/board_io.sv
`timescale 1ns/1ps

module board_io import bus_pkg::*, io_map_pkg::*; (
    input  logic     clk_48,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    input  logic     spi_miso,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output led_t     led,
    output logic     spi_cs,
    output logic     spi_clk,
    output logic     spi_mosi
);

    logic      spi_load;
    spi_byte_t spi_load_data;
    spi_byte_t spi_rx_data;
    logic      spi_busy;
    tmr_t      tmr_count;

    // ----------------------------------------------------------
    // Register block
    // ----------------------------------------------------------
    io_regs i_io_regs (
        .clk_48       (clk_48),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .spi_rx_data  (spi_rx_data),
        .spi_busy     (spi_busy),
        .tmr_count    (tmr_count),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .led          (led),
        .spi_cs       (spi_cs),
        .spi_load     (spi_load),
        .spi_load_data(spi_load_data)
    );

    // Config flash
    spi_master i_spi_master (
        .clk_48       (clk_48),
        .rst_n        (rst_n),
        .spi_load     (spi_load),
        .spi_load_data(spi_load_data),
        .spi_miso     (spi_miso),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_rx_data  (spi_rx_data),
        .spi_busy     (spi_busy)
    );

    us_timer i_us_timer (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .tmr_count(tmr_count)
    );

endmodule

// File: test/board_io_checker.sv
`timescale 1ns/1ps

module board_io_checker (
    input logic clk_48,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic spi_clk
);

    // ----------------------------------------------------------
    // Wishbone handshake
    // ----------------------------------------------------------
    ack_one_cycle: assert property (@(posedge clk_48) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    ack_after_request: assert property (@(posedge clk_48) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a request in the cycle before");

    // SPI clock low phase is one cycle
    clk_low_one_cycle: assert property (@(posedge clk_48) disable iff (!rst_n)
        !spi_clk |=> spi_clk)
        else $error("spi_clk low for more than one cycle");

endmodule

bind board_io board_io_checker i_board_io_checker (
    .clk_48 (clk_48),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .spi_clk(spi_clk)
);

// File: test/board_io_tb.sv
`timescale 1ns/1ps

module board_io_tb import bus_pkg::*, io_map_pkg::*; ();

    localparam int       timeout_cycles = 3000;
    localparam wb_addr_t unmapped_addr  = 8'h10;

    logic     clk_48;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    led_t     led;
    logic     spi_cs;
    logic     spi_clk;
    logic     spi_mosi;
    logic     spi_miso;

    int errors = 0;
    int cycles = 0;
    int seed;

    board_io i_board_io (
        .clk_48  (clk_48),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .spi_miso(spi_miso),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .led     (led),
        .spi_cs  (spi_cs),
        .spi_clk (spi_clk),
        .spi_mosi(spi_mosi)
    );

    // Flash stand-in returns every byte
    assign spi_miso = spi_mosi;

    initial clk_48 = 1'b0;
    always #10 clk_48 = ~clk_48;

    always @(posedge clk_48) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Bus access and checking
    // ----------------------------------------------------------
    task automatic check_eq(input string name, input wb_data_t expected, input wb_data_t actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("ERR %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t data,
                              output wb_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk_48);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        // Read data is only valid while ack is high
        do begin
            @(negedge clk_48);
            waited++;
        end while (!wb_ack && waited < 4);
        rdata = wb_dat_r;
        assert (wb_ack)
        else begin
            errors++;
            $display("No ack within 4 cycles for access to address %h", adr);
        end
        @(posedge clk_48);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        bus_access(1'b0, adr, '0, rdata);
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic reset_values();
        wb_data_t rd;
        wb_read(led_addr, rd);
        check_eq("wb_dat_r led", wb_data_t'(led_reset), rd);
        check_eq("led", wb_data_t'(led_reset), wb_data_t'(led));
        wb_read(spi_ctrl_addr, rd);
        check_eq("wb_dat_r spi ctrl", 32'h1, rd);
        check_eq("spi_cs", 32'h1, wb_data_t'(spi_cs));
        check_eq("spi_clk", 32'h1, wb_data_t'(spi_clk));
        check_eq("spi_mosi", 32'h1, wb_data_t'(spi_mosi));
        wb_read(tmr_addr, rd);
        assert (rd < 2)
        else begin
            errors++;
            $display("ERR tmr_count expected below %h got %h", 32'h2, rd);
        end
    endtask

    task automatic led_register();
        wb_data_t data;
        wb_data_t rd;
        led_t     val;
        repeat (6) begin
            // Upper bits are random too and must read as zero
            data = $random(seed);
            val  = data[2:0];
            wb_write(led_addr, data);
            wb_read(led_addr, rd);
            check_eq("wb_dat_r led", wb_data_t'(val), rd);
            check_eq("led", wb_data_t'(val), wb_data_t'(led));
        end
        wb_write(unmapped_addr, ~wb_data_t'(val));
        wb_read(led_addr, rd);
        check_eq("wb_dat_r led", wb_data_t'(val), rd);
        check_eq("led", wb_data_t'(val), wb_data_t'(led));
        wb_read(unmapped_addr, rd);
        check_eq("wb_dat_r unmapped", 32'h0, rd);
    endtask

    task automatic chip_select();
        wb_data_t rd;
        wb_write(spi_ctrl_addr, 32'h0);
        check_eq("spi_cs", 32'h0, wb_data_t'(spi_cs));
        wb_read(spi_ctrl_addr, rd);
        check_eq("wb_dat_r spi ctrl", 32'h0, rd);
        // Busy bit set in the write has no effect
        wb_write(spi_ctrl_addr, 32'h3);
        check_eq("spi_cs", 32'h1, wb_data_t'(spi_cs));
        wb_read(spi_ctrl_addr, rd);
        check_eq("wb_dat_r spi ctrl", 32'h1, rd);
    endtask

    task automatic spi_exchange();
        spi_byte_t tx;
        wb_data_t  rd;
        int        start;
        wb_write(spi_ctrl_addr, 32'h0);
        repeat (8) begin
            tx = spi_byte_t'($random(seed));
            wb_write(spi_data_addr, wb_data_t'(tx));
            start = cycles;
            do begin
                wb_read(spi_ctrl_addr, rd);
            end while (rd[spi_busy_bit] && (cycles - start) < 40);
            assert (!rd[spi_busy_bit])
            else begin
                errors++;
                $display("SPI busy still high 40 cycles after the byte was written");
            end
            wb_read(spi_data_addr, rd);
            check_eq("spi_rx_data", wb_data_t'(tx), rd);
        end
        wb_write(spi_ctrl_addr, 32'h1);
    endtask

    task automatic spi_clock_phases();
        spi_byte_t tx;
        int        lows;
        logic      prev;
        tx   = spi_byte_t'($random(seed));
        lows = 0;
        prev = 1'b1;
        fork
            wb_write(spi_data_addr, wb_data_t'(tx));
            repeat (30) begin
                @(negedge clk_48);
                if (prev && !spi_clk) begin
                    lows++;
                end
                prev = spi_clk;
            end
        join
        check_eq("spi_clk low phases", 32'd8, wb_data_t'(lows));
    endtask

    task automatic timer_count();
        wb_data_t t0;
        wb_data_t t1;
        wb_read(tmr_addr, t0);
        repeat (480) @(posedge clk_48);
        wb_read(tmr_addr, t1);
        assert ((t1 - t0) == 10 || (t1 - t0) == 11)
        else begin
            errors++;
            $display("ERR tmr_count delta expected %h or %h got %h", 32'd10, 32'd11, t1 - t0);
        end
        // Timer is read only
        wb_read(tmr_addr, t0);
        wb_write(tmr_addr, 32'h8000_0000);
        wb_read(tmr_addr, t1);
        assert ((t1 - t0) <= 1)
        else begin
            errors++;
            $display("ERR tmr_count expected %h or next got %h", t0, t1);
        end
    endtask

    initial begin
        seed     = 76;
        rst_n    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        repeat (4) @(posedge clk_48);
        rst_n <= 1'b1;
        reset_values();
        led_register();
        chip_select();
        spi_exchange();
        spi_clock_phases();
        timer_count();
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/bus_pkg.sv
logic/io_map_pkg.sv
logic/spi_master.sv
logic/us_timer.sv
logic/io_regs.sv
logic/board_io.sv
test/board_io_checker.sv
test/board_io_tb.sv

// File: Makefile
TOP := board_io_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
